//--- source/rob_retire_params.svh
`ifndef ROB_RETIRE_PARAMS_SVH
`define ROB_RETIRE_PARAMS_SVH

// width of a program counter.
`define XLEN 32

// a physical register index addresses 64 registers.
`define PR 6

// the ROB index width also sizes the in-flight writer distance.
`define ROB 4

// the reorder buffer holds 2**ROB entries.
`define ROB_DEPTH 16

`endif

//--- source/rob_retire_pkg.sv
`include "rob_retire_params.svh"

package rob_retire_pkg;

    // opcode class given at dispatch.
    typedef enum logic [1:0] {
        KIND_ALU    = 2'd0,
        KIND_BRANCH = 2'd1,
        KIND_STORE  = 2'd2
    } inst_kind_e;

    // one reorder buffer entry.
    // tnew is the destination register, told the mapping it replaced.
    typedef struct packed {
        logic [4:0]       arch_reg;
        logic [`PR-1:0]   tnew;
        logic [`PR-1:0]   told;
        logic             completed;
        logic             precise_state_need;
        logic [`XLEN-1:0] target_pc;
        logic             is_store;
    } rob_entry_t;

endpackage

//--- source/reorder_buffer.sv
`include "rob_retire_params.svh"

module reorder_buffer (
    input  logic                                  clock,
    input  logic                                  arst_n,
    input  logic [2:0]                            dispatch_en,
    input  logic [2:0][4:0]                       dispatch_arch_reg,
    input  rob_retire_pkg::inst_kind_e [2:0]      dispatch_kind,
    input  logic [2:0][`PR-1:0]                   dispatch_tnew,
    input  logic [2:0][`PR-1:0]                   dispatch_told,
    input  logic                                  complete_en,
    input  logic [`ROB-1:0]                       complete_idx,
    input  logic                                  complete_mispredict,
    input  logic [`XLEN-1:0]                      complete_target_pc,
    input  logic [1:0]                            commit_count,
    input  logic                                  flush,
    output rob_retire_pkg::rob_entry_t [2:0]      rob_head_entry,
    output logic [`ROB-1:0]                       fl_distance,
    output logic [2:0][`ROB-1:0]                  dispatch_idx,
    output logic                                  rob_full
);

    rob_retire_pkg::rob_entry_t entries [`ROB_DEPTH];

    logic [`ROB-1:0] head;
    logic [`ROB-1:0] tail;
    logic [`ROB:0]   count;

    logic [2:0][`ROB-1:0] win_idx;
    logic [2:0]           win_valid;
    logic [2:0]           win_writer;
    logic [2:0]           pop_mask;
    logic [2:0]           disp_writer;
    logic [1:0]           n_disp;
    logic [1:0]           disp_writers;
    logic [1:0]           pop_writers;

    // slot 2 is the oldest, so it lands at the tail.
    assign dispatch_idx[2] = tail;
    assign dispatch_idx[1] = tail + 1'b1;
    assign dispatch_idx[0] = tail + 2'd2;

    assign win_idx[2] = head;
    assign win_idx[1] = head + 1'b1;
    assign win_idx[0] = head + 2'd2;

    assign win_valid[2] = (count != '0);
    assign win_valid[1] = (count > 1);
    assign win_valid[0] = (count > 2);

    always_comb begin
        for (int s = 0; s < 3; s++) begin
            rob_head_entry[s]           = entries[win_idx[s]];
            rob_head_entry[s].completed = entries[win_idx[s]].completed & win_valid[s];
            win_writer[s]               = (entries[win_idx[s]].arch_reg != 5'd0);
            disp_writer[s]              = dispatch_en[s] & (dispatch_arch_reg[s] != 5'd0);
        end
    end

    // committed slots are always the leading ones of the window.
    assign pop_mask = {commit_count != 2'd0, commit_count[1], commit_count == 2'd3};

    assign n_disp = {1'b0, dispatch_en[2]} + {1'b0, dispatch_en[1]} + {1'b0, dispatch_en[0]};

    assign disp_writers = {1'b0, disp_writer[2]} + {1'b0, disp_writer[1]}
                        + {1'b0, disp_writer[0]};

    assign pop_writers = {1'b0, pop_mask[2] & win_writer[2]}
                       + {1'b0, pop_mask[1] & win_writer[1]}
                       + {1'b0, pop_mask[0] & win_writer[0]};

    assign rob_full = (count > (`ROB_DEPTH - 3));

    always_ff @(posedge clock) begin
        for (int s = 2; s >= 0; s--) begin
            if (dispatch_en[s]) begin
                entries[dispatch_idx[s]].arch_reg           <= dispatch_arch_reg[s];
                entries[dispatch_idx[s]].tnew               <= dispatch_tnew[s];
                entries[dispatch_idx[s]].told               <= dispatch_told[s];
                entries[dispatch_idx[s]].completed          <= 1'b0;
                entries[dispatch_idx[s]].precise_state_need <= 1'b0;
                entries[dispatch_idx[s]].target_pc          <= '0;
                entries[dispatch_idx[s]].is_store           <=
                    (dispatch_kind[s] == rob_retire_pkg::KIND_STORE);
            end
        end
        if (complete_en) begin
            entries[complete_idx].completed          <= 1'b1;
            entries[complete_idx].precise_state_need <= complete_mispredict;
            entries[complete_idx].target_pc          <= complete_target_pc;
        end
    end

    // the writer distance may wrap at 16; the retire stage only needs it modulo 2**ROB.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            fl_distance <= '0;
        end else if (flush) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            fl_distance <= '0;
        end else begin
            head        <= head + {{(`ROB-2){1'b0}}, commit_count};
            tail        <= tail + {{(`ROB-2){1'b0}}, n_disp};
            count       <= count + {{(`ROB-1){1'b0}}, n_disp}
                                 - {{(`ROB-1){1'b0}}, commit_count};
            fl_distance <= fl_distance + {{(`ROB-2){1'b0}}, disp_writers}
                                       - {{(`ROB-2){1'b0}}, pop_writers};
        end
    end

endmodule

//--- source/retire_stage.sv
`include "rob_retire_params.svh"

module retire_stage (
    input  rob_retire_pkg::rob_entry_t [2:0] rob_head_entry,
    input  logic [`ROB-1:0]                  fl_distance,
    input  logic [31:0][`PR-1:0]             archi_maptable,
    input  logic [`ROB+1:0]                  freelist_head,
    output logic                             recover_en,
    output logic [`XLEN-1:0]                 target_pc,
    output logic [2:0][4:0]                  map_ar,
    output logic [2:0][`PR-1:0]              map_ar_pr,
    output logic [31:0][`PR-1:0]             recover_maptable,
    output logic [2:0]                       retire_en,
    output logic [2:0]                       sq_retire_en,
    output logic [2:0][`PR-1:0]              told_out,
    output logic [`ROB+1:0]                  recover_head,
    output logic [1:0]                       commit_count
);

    logic [2:0]      is_writer;
    logic [1:0]      committed_writers;
    logic [`ROB-1:0] surviving;
    logic            stop;

    always_comb begin
        for (int s = 0; s < 3; s++) begin
            map_ar[s]    = rob_head_entry[s].arch_reg;
            map_ar_pr[s] = rob_head_entry[s].tnew;
            told_out[s]  = rob_head_entry[s].told;
            is_writer[s] = (rob_head_entry[s].arch_reg != 5'd0);
        end
    end

    // walk the window from the oldest slot and stop at the first incomplete entry,
    // or right after a completed branch that mispredicted.
    always_comb begin
        retire_en         = 3'b000;
        sq_retire_en      = 3'b000;
        recover_en        = 1'b0;
        target_pc         = '0;
        recover_maptable  = archi_maptable;
        commit_count      = 2'd0;
        committed_writers = 2'd0;
        stop              = 1'b0;
        for (int s = 2; s >= 0; s--) begin
            if (!stop) begin
                if (rob_head_entry[s].completed) begin
                    commit_count    = commit_count + 2'd1;
                    retire_en[s]    = is_writer[s];
                    sq_retire_en[s] = rob_head_entry[s].is_store;
                    if (is_writer[s]) begin
                        recover_maptable[rob_head_entry[s].arch_reg] = rob_head_entry[s].tnew;
                        committed_writers = committed_writers + 2'd1;
                    end
                    if (rob_head_entry[s].precise_state_need) begin
                        recover_en = 1'b1;
                        target_pc  = rob_head_entry[s].target_pc;
                        stop       = 1'b1;
                    end
                end else begin
                    stop = 1'b1;
                end
            end
        end
    end

    // writers left in the ROB after this commit hold registers that go back to the list.
    // at least one writer commits whenever all 16 entries write, so ROB bits are enough.
    assign surviving = fl_distance - {{(`ROB-2){1'b0}}, committed_writers};

    assign recover_head = freelist_head - {2'b00, surviving};

endmodule

//--- source/arch_map_table.sv
`include "rob_retire_params.svh"

module arch_map_table (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic [2:0]           retire_en,
    input  logic [2:0][4:0]      map_ar,
    input  logic [2:0][`PR-1:0]  map_ar_pr,
    output logic [31:0][`PR-1:0] archi_maptable
);

    localparam int PRW = `PR;

    // the committed map is the identity out of reset.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < 32; r++) begin
                archi_maptable[r] <= PRW'(r);
            end
        end else begin
            // older slots first, so a younger write to the same register wins.
            for (int s = 2; s >= 0; s--) begin
                if (retire_en[s]) begin
                    archi_maptable[map_ar[s]] <= map_ar_pr[s];
                end
            end
        end
    end

endmodule

//--- source/free_list.sv
`include "rob_retire_params.svh"

module free_list (
    input  logic                clock,
    input  logic                arst_n,
    input  logic [2:0]          alloc_en,
    output logic [2:0][`PR-1:0] alloc_pr,
    input  logic [2:0]          retire_en,
    input  logic [2:0][`PR-1:0] told_out,
    input  logic                recover_en,
    input  logic [`ROB+1:0]     recover_head,
    output logic [`ROB+1:0]     freelist_head
);

    localparam int PRW      = `PR;
    localparam int POSW     = `ROB + 2;
    localparam int FL_DEPTH = 32;

    logic [`PR-1:0] list [FL_DEPTH];

    logic [`ROB+1:0]      tail;
    logic [2:0][`ROB+1:0] alloc_pos;
    logic [2:0][`ROB+1:0] push_pos;
    logic [1:0]           n_alloc;
    logic [1:0]           n_push;

    // each enabled slot takes the next register after those of older slots.
    assign alloc_pos[2] = freelist_head;
    assign alloc_pos[1] = freelist_head + {{(POSW-1){1'b0}}, alloc_en[2]};
    assign alloc_pos[0] = alloc_pos[1] + {{(POSW-1){1'b0}}, alloc_en[1]};

    assign push_pos[2] = tail;
    assign push_pos[1] = tail + {{(POSW-1){1'b0}}, retire_en[2]};
    assign push_pos[0] = push_pos[1] + {{(POSW-1){1'b0}}, retire_en[1]};

    assign n_alloc = {1'b0, alloc_en[2]} + {1'b0, alloc_en[1]} + {1'b0, alloc_en[0]};
    assign n_push  = {1'b0, retire_en[2]} + {1'b0, retire_en[1]} + {1'b0, retire_en[0]};

    always_comb begin
        for (int s = 0; s < 3; s++) begin
            alloc_pr[s] = list[alloc_pos[s][`ROB:0]];
        end
    end

    // registers above the architectural range start out free.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                list[i] <= PRW'(i + FL_DEPTH);
            end
            freelist_head <= '0;
            tail          <= POSW'(FL_DEPTH);
        end else begin
            for (int s = 2; s >= 0; s--) begin
                if (retire_en[s]) begin
                    list[push_pos[s][`ROB:0]] <= told_out[s];
                end
            end
            tail <= tail + {{(POSW-2){1'b0}}, n_push};
            if (recover_en) begin
                freelist_head <= recover_head;
            end else begin
                freelist_head <= freelist_head + {{(POSW-2){1'b0}}, n_alloc};
            end
        end
    end

endmodule

//--- source/rob_retire_top.sv
`include "rob_retire_params.svh"

module rob_retire_top (
    input  logic                             clock,
    input  logic                             arst_n,
    input  logic [2:0]                       dispatch_en,
    input  logic [2:0][4:0]                  dispatch_arch_reg,
    input  rob_retire_pkg::inst_kind_e [2:0] dispatch_kind,
    input  logic [2:0][`PR-1:0]              dispatch_told,
    input  logic                             complete_en,
    input  logic [`ROB-1:0]                  complete_idx,
    input  logic                             complete_mispredict,
    input  logic [`XLEN-1:0]                 complete_target_pc,
    output logic [2:0][`ROB-1:0]             dispatch_idx,
    output logic [2:0][`PR-1:0]              alloc_pr,
    output logic                             rob_full,
    output logic [2:0]                       retire_en,
    output logic [2:0]                       sq_retire_en,
    output logic                             recover_en,
    output logic [`XLEN-1:0]                 target_pc,
    output logic [2:0][4:0]                  map_ar,
    output logic [2:0][`PR-1:0]              map_ar_pr,
    output logic [2:0][`PR-1:0]              told_out,
    output logic [31:0][`PR-1:0]             recover_maptable,
    output logic [1:0]                       commit_count
);

    rob_retire_pkg::rob_entry_t [2:0] rob_head_entry;

    logic [`ROB-1:0]      fl_distance;
    logic [31:0][`PR-1:0] archi_maptable;
    logic [`ROB+1:0]      freelist_head;
    logic [`ROB+1:0]      recover_head;
    logic [2:0]           alloc_en;

    // only slots that write a register take one from the free list.
    assign alloc_en[2] = dispatch_en[2] & (dispatch_arch_reg[2] != 5'd0);
    assign alloc_en[1] = dispatch_en[1] & (dispatch_arch_reg[1] != 5'd0);
    assign alloc_en[0] = dispatch_en[0] & (dispatch_arch_reg[0] != 5'd0);

    reorder_buffer i_reorder_buffer (
        .clock               (clock),
        .arst_n              (arst_n),
        .dispatch_en         (dispatch_en),
        .dispatch_arch_reg   (dispatch_arch_reg),
        .dispatch_kind       (dispatch_kind),
        .dispatch_tnew       (alloc_pr),
        .dispatch_told       (dispatch_told),
        .complete_en         (complete_en),
        .complete_idx        (complete_idx),
        .complete_mispredict (complete_mispredict),
        .complete_target_pc  (complete_target_pc),
        .commit_count        (commit_count),
        .flush               (recover_en),
        .rob_head_entry      (rob_head_entry),
        .fl_distance         (fl_distance),
        .dispatch_idx        (dispatch_idx),
        .rob_full            (rob_full)
    );

    retire_stage i_retire_stage (
        .rob_head_entry   (rob_head_entry),
        .fl_distance      (fl_distance),
        .archi_maptable   (archi_maptable),
        .freelist_head    (freelist_head),
        .recover_en       (recover_en),
        .target_pc        (target_pc),
        .map_ar           (map_ar),
        .map_ar_pr        (map_ar_pr),
        .recover_maptable (recover_maptable),
        .retire_en        (retire_en),
        .sq_retire_en     (sq_retire_en),
        .told_out         (told_out),
        .recover_head     (recover_head),
        .commit_count     (commit_count)
    );

    arch_map_table i_arch_map_table (
        .clock          (clock),
        .arst_n         (arst_n),
        .retire_en      (retire_en),
        .map_ar         (map_ar),
        .map_ar_pr      (map_ar_pr),
        .archi_maptable (archi_maptable)
    );

    free_list i_free_list (
        .clock         (clock),
        .arst_n        (arst_n),
        .alloc_en      (alloc_en),
        .alloc_pr      (alloc_pr),
        .retire_en     (retire_en),
        .told_out      (told_out),
        .recover_en    (recover_en),
        .recover_head  (recover_head),
        .freelist_head (freelist_head)
    );

endmodule

//--- verif/rob_retire_tb.sv
`include "rob_retire_params.svh"

module rob_retire_tb;

    localparam int OP_IDLE  = 0;
    localparam int OP_DISP  = 1;
    localparam int OP_COMP  = 2;
    localparam int OP_DRAIN = 3;
    localparam int TIMEOUT  = 200;

    typedef struct packed {
        logic [3:0]      test;
        logic [1:0]      op;
        logic [1:0]      n;
        logic [2:0][4:0] ar;
        logic [2:0][1:0] knd;
        logic [3:0]      pos;
        logic            mis;
        logic            chk;
        logic [1:0]      exp_cc;
    } step_t;

    // model ROB entries queue up with the oldest at the front.
    typedef struct packed {
        logic [4:0]       ar;
        logic [`PR-1:0]   tnew;
        logic [`PR-1:0]   told;
        logic             done;
        logic             mis;
        logic             store;
        logic             branch;
        logic [`XLEN-1:0] pc;
        logic [`ROB-1:0]  idx;
    } model_entry_t;

    logic                             clock;
    logic                             arst_n;
    logic [2:0]                       dispatch_en;
    logic [2:0][4:0]                  dispatch_arch_reg;
    rob_retire_pkg::inst_kind_e [2:0] dispatch_kind;
    logic [2:0][`PR-1:0]              dispatch_told;
    logic                             complete_en;
    logic [`ROB-1:0]                  complete_idx;
    logic                             complete_mispredict;
    logic [`XLEN-1:0]                 complete_target_pc;
    logic [2:0][`ROB-1:0]             dispatch_idx;
    logic [2:0][`PR-1:0]              alloc_pr;
    logic                             rob_full;
    logic [2:0]                       retire_en;
    logic [2:0]                       sq_retire_en;
    logic                             recover_en;
    logic [`XLEN-1:0]                 target_pc;
    logic [2:0][4:0]                  map_ar;
    logic [2:0][`PR-1:0]              map_ar_pr;
    logic [2:0][`PR-1:0]              told_out;
    logic [31:0][`PR-1:0]             recover_maptable;
    logic [1:0]                       commit_count;

    model_entry_t   mq [$];
    step_t          steps [$];
    logic [`PR-1:0] m_fl [32];
    logic [`PR-1:0] arch_map [32];
    logic [`PR-1:0] spec_map [32];
    logic [`ROB-1:0] m_tail_idx;
    logic [1:0]     pend_exp;
    bit             pend_chk;
    int             m_fl_head, m_fl_tail, errors, checks, pc_seq;

    rob_retire_top i_rob_retire_top (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic add_step(input int test, input int op, input int n, input logic [14:0] ar,
                            input logic [5:0] knd, input int pos, input bit mis,
                            input bit chk, input int exp_cc);
        step_t st;
        st = '{test[3:0], op[1:0], n[1:0], ar, knd, pos[3:0], mis, chk, exp_cc[1:0]};
        steps.push_back(st);
    endtask

    // predicts one cycle of in-order commit and applies it to the model.
    task automatic model_commit(output bit rec);
        logic [2:0]       exp_ret;
        logic [2:0]       exp_sq;
        logic [`XLEN-1:0] exp_pc;
        int               cc;
        int               surv;
        exp_ret = '0;
        exp_sq  = '0;
        exp_pc  = '0;
        rec     = 1'b0;
        cc      = 0;
        check_val("rob_full", rob_full, (`ROB_DEPTH - mq.size()) < 3);
        for (int s = 2; s >= 0; s--) begin
            if (cc == 2 - s && !rec && cc < mq.size() && mq[cc].done) begin
                if (mq[cc].ar != 0) begin
                    exp_ret[s] = 1'b1;
                    check_val("told_out", told_out[s], mq[cc].told);
                    check_val("map_ar", map_ar[s], mq[cc].ar);
                    check_val("map_ar_pr", map_ar_pr[s], mq[cc].tnew);
                end
                exp_sq[s] = mq[cc].store;
                if (mq[cc].mis) begin
                    rec    = 1'b1;
                    exp_pc = mq[cc].pc;
                end
                cc++;
            end
        end
        check_val("retire_en", retire_en, exp_ret);
        check_val("sq_retire_en", sq_retire_en, exp_sq);
        check_val("recover_en", recover_en, rec);
        check_val("commit_count", commit_count, cc);
        if (rec) check_val("target_pc", target_pc, exp_pc);
        for (int k = 0; k < cc; k++) begin
            if (mq[0].ar != 0) begin
                arch_map[mq[0].ar] = mq[0].tnew;
                m_fl[m_fl_tail % 32] = mq[0].told;
                m_fl_tail++;
            end
            void'(mq.pop_front());
        end
        if (rec) begin
            for (int r = 0; r < 32; r++) begin
                check_val("recover_maptable", recover_maptable[r], arch_map[r]);
            end
            surv = 0;
            foreach (mq[k]) if (mq[k].ar != 0) surv++;
            // registers of flushed writers go back to the head of the free list.
            m_fl_head -= surv;
            mq.delete();
            m_tail_idx = '0;
            spec_map   = arch_map;
        end
    endtask

    task automatic sample_cycle(output bit rec);
        @(negedge clock);
        if (pend_chk) check_val("commit_count", commit_count, pend_exp);
        pend_chk = 1'b0;
        model_commit(rec);
        dispatch_en         = '0;
        complete_en         = 1'b0;
        complete_mispredict = 1'b0;
    endtask

    // a busy or missing position falls back to the oldest incomplete entry.
    task automatic complete_at(input int pos, input bit mis);
        int p;
        p = pos;
        if (p >= mq.size() || mq[p].done) begin
            p = -1;
            foreach (mq[k]) if (p < 0 && !mq[k].done) p = k;
        end
        if (p >= 0) begin
            pc_seq++;
            complete_en         = 1'b1;
            complete_idx        = mq[p].idx;
            complete_mispredict = mis & mq[p].branch;
            complete_target_pc  = 32'h8000_0000 + pc_seq * 4;
            mq[p].done = 1'b1;
            mq[p].mis  = complete_mispredict;
            mq[p].pc   = complete_target_pc;
        end
    endtask

    task automatic dispatch_slots(input step_t st);
        model_entry_t   e;
        logic [`PR-1:0] exp_pr [3];
        logic [`ROB-1:0] exp_idx [3];
        for (int s = 2; s >= 3 - int'(st.n); s--) begin
            e = '0;
            e.ar     = st.ar[s];
            e.told   = spec_map[e.ar];
            e.store  = (st.knd[s] == 2'd2);
            e.branch = (st.knd[s] == 2'd1);
            e.idx    = m_tail_idx;
            if (e.ar != 0) begin
                e.tnew = m_fl[m_fl_head % 32];
                m_fl_head++;
                spec_map[e.ar] = e.tnew;
            end
            exp_pr[s]  = e.tnew;
            exp_idx[s] = m_tail_idx;
            dispatch_en[s]       = 1'b1;
            dispatch_arch_reg[s] = e.ar;
            dispatch_kind[s]     = rob_retire_pkg::inst_kind_e'(st.knd[s]);
            dispatch_told[s]     = e.told;
            mq.push_back(e);
            m_tail_idx++;
        end
        #1;
        for (int s = 2; s >= 3 - int'(st.n); s--) begin
            check_val("dispatch_idx", dispatch_idx[s], exp_idx[s]);
            if (dispatch_arch_reg[s] != 0) check_val("alloc_pr", alloc_pr[s], exp_pr[s]);
        end
    endtask

    task automatic drain();
        bit rec;
        int waited;
        waited = 0;
        while (mq.size() != 0 && waited < TIMEOUT) begin
            sample_cycle(rec);
            if (!rec) complete_at(0, 1'b0);
            waited++;
        end
        if (mq.size() != 0) begin
            $display("timeout: the ROB did not drain within %0d cycles", TIMEOUT);
            errors++;
        end
    endtask

    task automatic build_table();
        int cnt;
        int n;
        add_step(1, OP_DISP, 3, {5'd1, 5'd2, 5'd3}, 6'h00, 0, 0, 1, 0);
        add_step(1, OP_COMP, 0, '0, '0, 2, 0, 1, 0);
        add_step(1, OP_COMP, 0, '0, '0, 1, 0, 1, 0);
        add_step(1, OP_COMP, 0, '0, '0, 0, 0, 1, 3);
        add_step(1, OP_IDLE, 0, '0, '0, 0, 0, 0, 0);
        add_step(2, OP_DISP, 3, {5'd5, 5'd0, 5'd6}, 6'h00, 0, 0, 1, 0);
        add_step(2, OP_COMP, 0, '0, '0, 2, 0, 1, 0);
        add_step(2, OP_COMP, 0, '0, '0, 1, 0, 1, 0);
        add_step(2, OP_COMP, 0, '0, '0, 0, 0, 1, 3);
        add_step(2, OP_DISP, 3, {5'd0, 5'd0, 5'd7}, 6'h00, 0, 0, 0, 0);
        add_step(2, OP_DRAIN, 0, '0, '0, 0, 0, 0, 0);
        add_step(3, OP_DISP, 3, {5'd0, 5'd7, 5'd8}, {2'd2, 2'd2, 2'd0}, 0, 0, 1, 0);
        add_step(3, OP_COMP, 0, '0, '0, 1, 0, 1, 0);
        add_step(3, OP_COMP, 0, '0, '0, 0, 0, 1, 2);
        add_step(3, OP_COMP, 0, '0, '0, 0, 0, 1, 1);
        add_step(3, OP_IDLE, 0, '0, '0, 0, 0, 0, 0);
        for (int i = 0; i < 12; i++) begin
            add_step(4, OP_DISP, 3, {5'((3 * i) % 31 + 1), 5'((3 * i + 1) % 31 + 1),
                     5'((3 * i + 2) % 31 + 1)}, 6'h00, 0, 0, 0, 0);
        end
        add_step(4, OP_DRAIN, 0, '0, '0, 0, 0, 0, 0);
        add_step(5, OP_DISP, 3, {5'd3, 5'd0, 5'd4}, {2'd0, 2'd1, 2'd0}, 0, 0, 1, 0);
        add_step(5, OP_DISP, 3, {5'd9, 5'd10, 5'd11}, 6'h00, 0, 0, 0, 0);
        // fill the ROB so that the flush has to clear rob_full.
        for (int i = 0; i < 3; i++) begin
            add_step(5, OP_DISP, 3, {5'(15 + 3 * i), 5'(16 + 3 * i), 5'(17 + 3 * i)}, 6'h00,
                     0, 0, 0, 0);
        end
        add_step(5, OP_COMP, 0, '0, '0, 2, 0, 1, 0);
        add_step(5, OP_COMP, 0, '0, '0, 1, 1, 1, 0);
        add_step(5, OP_COMP, 0, '0, '0, 0, 0, 1, 2);
        add_step(5, OP_DISP, 3, {5'd12, 5'd13, 5'd14}, 6'h00, 0, 0, 0, 0);
        add_step(5, OP_DRAIN, 0, '0, '0, 0, 0, 0, 0);
        cnt = 0;
        while (cnt < 200) begin
            n = (200 - cnt < 3) ? 200 - cnt : 1 + $urandom % 3;
            add_step(6, OP_DISP, n, 15'($urandom), {2'($urandom % 3), 2'($urandom % 3),
                     2'($urandom % 3)}, 0, 0, 0, 0);
            cnt += n;
            repeat (1 + $urandom % 2) add_step(6, OP_COMP, 0, '0, '0, $urandom % 8,
                                               ($urandom % 10) == 0, 0, 0);
        end
        add_step(6, OP_DRAIN, 0, '0, '0, 0, 0, 0, 0);
    endtask

    initial begin
        step_t st;
        bit    rec;
        int    i, retries, cur_test, test_base;
        void'($urandom(83));
        arst_n = 1'b0;
        dispatch_en = '0;
        dispatch_arch_reg = '0;
        for (int s = 0; s < 3; s++) begin
            dispatch_kind[s] = rob_retire_pkg::KIND_ALU;
        end
        dispatch_told = '0;
        complete_en = 1'b0;
        complete_idx = '0;
        complete_mispredict = 1'b0;
        complete_target_pc = '0;
        for (int r = 0; r < 32; r++) begin
            m_fl[r] = `PR'(r + 32);
            arch_map[r] = `PR'(r);
        end
        spec_map = arch_map;
        m_fl_head = 0;
        m_fl_tail = 32;
        m_tail_idx = '0;
        build_table();
        repeat (5) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        i = 0;
        retries = 0;
        cur_test = steps[0].test;
        test_base = 0;
        while (i < steps.size()) begin
            st = steps[i];
            if (st.test != cur_test) begin
                $display("test %0d done: %0d errors", cur_test, errors - test_base);
                cur_test = st.test;
                test_base = errors;
            end
            if (st.op == OP_DRAIN) begin
                drain();
                i++;
            end else begin
                sample_cycle(rec);
                if (st.op == OP_DISP && (rec || rob_full)) begin
                    // held off this cycle, so keep the ROB moving and try again.
                    if (!rec) complete_at(0, 1'b0);
                    retries++;
                    if (retries > TIMEOUT) begin
                        $display("timeout: step %0d could not dispatch", i);
                        errors++;
                        i = steps.size();
                    end
                end else begin
                    if (st.op == OP_DISP) dispatch_slots(st);
                    if (st.op == OP_COMP && !rec) complete_at(st.pos, st.mis);
                    pend_chk = st.chk;
                    pend_exp = st.exp_cc;
                    retries = 0;
                    i++;
                end
            end
        end
        $display("test %0d done: %0d errors", cur_test, errors - test_base);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- rob_retire.f
+incdir+source
source/rob_retire_pkg.sv
source/reorder_buffer.sv
source/retire_stage.sv
source/arch_map_table.sv
source/free_list.sv
source/rob_retire_top.sv
verif/rob_retire_tb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module rob_retire_tb -f rob_retire.f &&
out="$(./obj_dir/Vrob_retire_tb)" &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -qx 'TB PASSED' ||
{ echo "simulation did not pass"; exit 1; }
